//--- Makefile
# Verilator build and run of the data-memory subsystem testbench

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check sim.log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -f verilog.f --top-module tb_mem_subsys -Mdir obj_dir
	./obj_dir/Vtb_mem_subsys +verilator+error+limit+1000 | tee sim.log
	@if grep -q "Regression failed" sim.log; then \
		echo "simulation reported failure"; exit 1; \
	fi
	@if ! grep -q "Regression passed" sim.log; then \
		echo "simulation ended without a result"; exit 1; \
	fi

clean:
	rm -rf obj_dir sim.log

//--- verification/mem_subsys_asserts.sv
/*
 * Bound checks for the data-memory subsystem.
 * Compares each cache response with the expected word and error,
 * and checks hit latency and readiness, word alignment and
 * write-back status.
 */
module mem_subsys_asserts (
    input logic                    clk,
    input logic                    reset,
    input memif_pkg::cache_req_t   dreq,
    input logic                    req_ready,
    input memif_pkg::cache_resp_t  dresp,
    input logic                    is_writebacked_all,
    input basic_pkg::word_t        exp_rdata,
    input logic                    exp_error,
    input logic                    exp_check_data,
    input logic                    exp_hit,
    input logic                    check_dirty
);

    // failures so far
    int fail_count = 0;

    a_align: assert property (@(posedge clk) disable iff (reset)
        dreq.valid |-> (dreq.addr[1:0] == 2'b00))
    else begin
        fail_count++;
        $error("request address %h is not word aligned", $sampled(dreq.addr));
    end

    // hit answers in the cycle after acceptance and is ready again then
    a_hit_latency: assert property (@(posedge clk) disable iff (reset)
        (dreq.valid && req_ready && exp_hit) |=> (dresp.valid && req_ready))
    else begin
        fail_count++;
        $error("hit response or ready did not come in the cycle after acceptance");
    end

    a_rdata: assert property (@(posedge clk) disable iff (reset)
        (dresp.valid && exp_check_data) |-> (dresp.rdata == exp_rdata))
    else begin
        fail_count++;
        $error("[FAIL] %0t dresp.rdata: got %h, expected %h",
               $time, $sampled(dresp.rdata), $sampled(exp_rdata));
    end

    a_error: assert property (@(posedge clk) disable iff (reset)
        dresp.valid |-> (dresp.error == exp_error))
    else begin
        fail_count++;
        $error("[FAIL] %0t dresp.error: got %b, expected %b",
               $time, $sampled(dresp.error), $sampled(exp_error));
    end

    // clean right after reset
    a_reset_status: assert property (@(posedge clk)
        $fell(reset) |-> is_writebacked_all)
    else begin
        fail_count++;
        $error("[FAIL] %0t is_writebacked_all: got 0, expected 1", $time);
    end

    a_dirty_status: assert property (@(posedge clk) disable iff (reset)
        check_dirty |-> !is_writebacked_all)
    else begin
        fail_count++;
        $error("[FAIL] %0t is_writebacked_all: got 1, expected 0", $time);
    end

endmodule

//--- verification/tb_mem_subsys.sv
/*
 * Testbench for the data-memory subsystem.
 * Drives loads, stores, PTE updates and forced write-backs into the
 * cache, keeps a shadow memory and publishes the expected response
 * for the bound assertions, which do the checking.
 */
module tb_mem_subsys;

    // every access is bounded by an eviction plus a refill
    localparam int ACCESS_COUNT = 250;
    localparam int ACCESS_CYCLES = 16;
    localparam int WALK_CYCLES = 4 * basic_pkg::CACHE_LINES;
    localparam int TIMEOUT_CYCLES = ACCESS_COUNT * ACCESS_CYCLES + WALK_CYCLES + 100;
    localparam int RANDOM_WORDS = 24;
    localparam int RANDOM_OPS = 200;

    logic                    clk;
    logic                    reset;
    memif_pkg::cache_req_t   dreq;
    logic                    req_ready;
    memif_pkg::cache_resp_t  dresp;
    logic                    do_writeback;
    logic                    is_writebacked_all;

    // expected response, read by the bound assertions
    basic_pkg::word_t        exp_rdata;
    logic                    exp_error;
    logic                    exp_check_data;
    logic                    exp_hit;
    logic                    check_dirty;

    basic_pkg::word_t        shadow [int];
    basic_pkg::addr_t        tag_model [basic_pkg::CACHE_LINES];
    logic [basic_pkg::CACHE_LINES-1:0] tag_valid;
    logic [31:0]             rng_state;
    int                      cycles = 0;
    int                      tests_run;
    int                      tests_failed;
    int                      last_fail_count;

    mem_subsys_top dut0 (
        .clk                (clk),
        .reset              (reset),
        .dreq               (dreq),
        .req_ready          (req_ready),
        .dresp              (dresp),
        .do_writeback       (do_writeback),
        .is_writebacked_all (is_writebacked_all)
    );

    bind mem_subsys_top mem_subsys_asserts asserts0 (
        .clk                (clk),
        .reset              (reset),
        .dreq               (dreq),
        .req_ready          (req_ready),
        .dresp              (dresp),
        .is_writebacked_all (is_writebacked_all),
        .exp_rdata          (tb_mem_subsys.exp_rdata),
        .exp_error          (tb_mem_subsys.exp_error),
        .exp_check_data     (tb_mem_subsys.exp_check_data),
        .exp_hit            (tb_mem_subsys.exp_hit),
        .check_dirty        (tb_mem_subsys.check_dirty)
    );

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [31:0] next_random();
        rng_state = xorshift(rng_state);
        return rng_state;
    endfunction

    // byte n of the new word replaces byte n of the old one when mask bit n is set
    function automatic basic_pkg::word_t apply_mask(input basic_pkg::word_t old_word,
                                                     input basic_pkg::word_t new_word,
                                                     input basic_pkg::wmask_t mask);
        basic_pkg::word_t result;
        for (int b = 0; b < 4; b++) begin
            result[b*8 +: 8] = mask[b] ? new_word[b*8 +: 8] : old_word[b*8 +: 8];
        end
        return result;
    endfunction

    // eight indices, three conflicting words on each
    function automatic basic_pkg::addr_t random_addr(input int i);
        return basic_pkg::addr_t'(32'h800 + (i % 8) * 4 + (i / 8) * 64);
    endfunction

    task automatic access(input basic_pkg::addr_t addr, input logic wen,
                          input basic_pkg::word_t wdata, input basic_pkg::wmask_t mask,
                          input logic pte_a, input logic pte_d);
        int word;
        int index;
        logic in_range;
        basic_pkg::word_t old_word;
        word = int'(addr >> 2);
        index = int'(addr[5:2]);
        in_range = (addr < 32'h4000);
        old_word = shadow.exists(word) ? shadow[word] : '0;
        while (!req_ready) begin
            @(negedge clk);
        end
        exp_hit = tag_valid[index] && (tag_model[index] == addr);
        exp_error = !in_range;
        exp_check_data = in_range;
        exp_rdata = old_word;
        if (wen) begin
            exp_rdata = apply_mask(old_word, wdata, mask);
        end else if (pte_a || pte_d) begin
            // PTE accesses return no defined data
            exp_check_data = 1'b0;
        end
        if (in_range && wen) begin
            shadow[word] = exp_rdata;
        end else if (in_range && (pte_a || pte_d)) begin
            shadow[word] = old_word | 32'h40 | (pte_d ? 32'h80 : 32'h0);
        end
        tag_valid[index] = in_range;
        tag_model[index] = addr;
        dreq = '{valid: 1'b1, wen: wen, addr: addr, wdata: wdata, wmask: mask,
                 pte_a: pte_a, pte_d: pte_d};
        @(negedge clk);
        dreq.valid = 1'b0;
        while (!dresp.valid) begin
            @(negedge clk);
        end
        // expectation stays put through the response edge
        @(negedge clk);
    endtask

    task automatic finish_test(input string name);
        int failures;
        failures = dut0.asserts0.fail_count - last_fail_count;
        last_fail_count = dut0.asserts0.fail_count;
        tests_run++;
        if (failures != 0) begin
            tests_failed++;
            $display("test %s: %0d check failures", name, failures);
        end else begin
            $display("test %s: ok", name);
        end
    endtask

    initial begin
        clk = 1'b0;
        forever begin
            #4 clk = ~clk;
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles > TIMEOUT_CYCLES) begin
            $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Regression failed");
            $finish;
        end
    end

    initial begin
        logic [31:0] r;
        logic [31:0] data;
        logic [31:0] mask_bits;
        reset = 1'b1;
        dreq = '0;
        do_writeback = 1'b0;
        exp_rdata = '0;
        exp_error = 1'b0;
        exp_check_data = 1'b0;
        exp_hit = 1'b0;
        check_dirty = 1'b0;
        tag_valid = '0;
        rng_state = 32'hca83;
        tests_run = 0;
        tests_failed = 0;
        last_fail_count = 0;
        repeat (4) @(negedge clk);
        reset = 1'b0;
        @(negedge clk);

        access(32'h100, 1'b1, 32'h1122_3344, 4'hf, 1'b0, 1'b0);
        access(32'h100, 1'b1, 32'h0000_00aa, 4'h1, 1'b0, 1'b0);
        access(32'h100, 1'b1, 32'h00bb_0000, 4'h4, 1'b0, 1'b0);
        access(32'h100, 1'b0, '0, '0, 1'b0, 1'b0);
        finish_test("store_load");

        // 64 bytes apart, same line
        access(32'h200, 1'b1, 32'hcafe_0001, 4'hf, 1'b0, 1'b0);
        access(32'h240, 1'b1, 32'hcafe_0002, 4'hf, 1'b0, 1'b0);
        access(32'h200, 1'b0, '0, '0, 1'b0, 1'b0);
        finish_test("conflict_evict");

        access(32'h4000, 1'b0, '0, '0, 1'b0, 1'b0);
        access(32'h240, 1'b0, '0, '0, 1'b0, 1'b0);
        finish_test("out_of_range");

        access(32'h300, 1'b1, 32'h5a5a_5a00, 4'hf, 1'b0, 1'b0);
        access(32'h300, 1'b0, '0, '0, 1'b1, 1'b0);
        access(32'h300, 1'b0, '0, '0, 1'b0, 1'b0);
        access(32'h300, 1'b0, '0, '0, 1'b1, 1'b1);
        access(32'h300, 1'b0, '0, '0, 1'b0, 1'b0);
        finish_test("pte_update");

        for (int i = 0; i < 4; i++) begin
            access(basic_pkg::addr_t'(32'h100 + i * 68), 1'b1, next_random(), 4'hf,
                   1'b0, 1'b0);
        end
        check_dirty = 1'b1;
        @(negedge clk);
        check_dirty = 1'b0;
        do_writeback = 1'b1;
        @(negedge clk);
        do_writeback = 1'b0;
        while (!is_writebacked_all) begin
            @(negedge clk);
        end
        tag_valid = '0;
        for (int i = 0; i < 4; i++) begin
            access(basic_pkg::addr_t'(32'h100 + i * 68), 1'b0, '0, '0, 1'b0, 1'b0);
        end
        finish_test("forced_writeback");

        for (int i = 0; i < RANDOM_WORDS; i++) begin
            access(random_addr(i), 1'b1, next_random(), 4'hf, 1'b0, 1'b0);
        end
        for (int n = 0; n < RANDOM_OPS; n++) begin
            r = next_random();
            data = next_random();
            mask_bits = next_random();
            access(random_addr(int'(r % RANDOM_WORDS)), r[31], data, mask_bits[3:0],
                   1'b0, 1'b0);
        end
        finish_test("random_mix");

        $display("tests run %0d, tests failed %0d, check failures %0d",
                 tests_run, tests_failed, dut0.asserts0.fail_count);
        if (tests_failed == 0 && dut0.asserts0.fail_count == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

//--- verilog.f
verilog/basic_pkg.sv
verilog/memif_pkg.sv
verilog/dcache.sv
verilog/main_memory.sv
verilog/mem_subsys_top.sv
verification/mem_subsys_asserts.sv
verification/tb_mem_subsys.sv

//--- verilog/basic_pkg.sv
/*
 * Basic types for the data-memory stage.
 * Data word, byte address and byte-enable mask types, plus the
 * geometry of the direct-mapped data cache.
 */
package basic_pkg;

    // 32-bit data word and byte address
    typedef logic [31:0] word_t;
    typedef logic [31:0] addr_t;

    // bit n enables byte n of a word
    typedef logic [3:0] wmask_t;

    // index comes from address bits 5..2, so 16 lines
    localparam int CACHE_INDEX_BITS = 4;
    localparam int CACHE_LINES = 1 << CACHE_INDEX_BITS;

    typedef logic [CACHE_INDEX_BITS-1:0] cache_index_t;

    // one extra bit so that all lines can be counted
    typedef logic [CACHE_INDEX_BITS:0] modified_count_t;

endpackage

//--- verilog/dcache.sv
/*
 * Direct-mapped write-back data cache, one word per line.
 * Serves word loads, byte-masked stores and page-table-entry updates
 * that set the A and D bits in place. A write-back strobe walks all
 * lines, writes dirty ones to memory and invalidates them; the status
 * output is high once no dirty data is left.
 */
module dcache (
    input  logic                    clk,
    input  logic                    reset,
    input  memif_pkg::cache_req_t   dreq,
    output logic                    req_ready,
    output memif_pkg::cache_resp_t  dresp,
    output memif_pkg::mem_req_t     mem_req,
    input  logic                    mem_req_ready,
    input  memif_pkg::mem_resp_t    mem_resp,
    input  logic                    do_writeback,
    output logic                    is_writebacked_all
);

    typedef enum logic [2:0] {
        idle,
        read_req,
        read_wait,
        resp,
        evict_req,
        walk_check,
        walk_req
    } state_t;

    // merge new bytes into a word under the mask
    function automatic basic_pkg::word_t merge_bytes(
        input basic_pkg::word_t  old_word,
        input basic_pkg::word_t  new_word,
        input basic_pkg::wmask_t mask
    );
        basic_pkg::word_t merged;
        merged = old_word;
        for (int b = 0; b < 4; b++) begin
            if (mask[b]) begin
                merged[b*8 +: 8] = new_word[b*8 +: 8];
            end
        end
        return merged;
    endfunction

    // line contents after applying a request to its current word
    function automatic basic_pkg::word_t update_word(
        input basic_pkg::word_t      base,
        input memif_pkg::cache_req_t req
    );
        if (req.wen) begin
            return merge_bytes(base, req.wdata, req.wmask);
        end else if (req.pte_a || req.pte_d) begin
            // A always, D only when asked
            return base | {24'h0, req.pte_d, 1'b1, 6'h0};
        end
        return base;
    endfunction

    // line storage
    basic_pkg::word_t               line_data [basic_pkg::CACHE_LINES];
    basic_pkg::addr_t               line_tag [basic_pkg::CACHE_LINES];
    logic [basic_pkg::CACHE_LINES-1:0] line_valid;
    logic [basic_pkg::CACHE_LINES-1:0] line_modified;

    state_t                         state;
    memif_pkg::cache_req_t          saved_req;
    memif_pkg::cache_req_t          cur_req;
    basic_pkg::cache_index_t        cur_index;
    basic_pkg::cache_index_t        walk_index;
    basic_pkg::cache_index_t        wb_index;
    basic_pkg::modified_count_t     modified_count;
    logic                           wb_pending;

    // pending write-back word
    basic_pkg::addr_t               wb_addr;
    basic_pkg::word_t               wb_data;

    logic                           hit_valid_q;
    logic                           resp_error_q;
    basic_pkg::word_t               resp_rdata_q;

    basic_pkg::word_t               base_word;
    basic_pkg::word_t               new_word;
    basic_pkg::word_t               resp_word;
    logic                           word_changed;
    logic                           line_hit;
    logic                           accept;
    logic                           hit_access;
    logic                           miss_access;
    logic                           evict_start;
    logic                           refill_done;
    logic                           refill_ok;
    logic                           walk_start;
    logic                           walk_active;
    logic                           walk_dirty;
    logic                           wb_load;
    logic                           count_inc;
    logic                           count_dec;

    // the live request in idle, the saved one while busy
    assign cur_req   = (state == idle) ? dreq : saved_req;
    assign cur_index = cur_req.addr[basic_pkg::CACHE_INDEX_BITS+1:2];
    assign line_hit  = line_valid[cur_index] && (line_tag[cur_index] == cur_req.addr);

    assign accept      = (state == idle) && dreq.valid;
    assign hit_access  = accept && line_hit;
    assign miss_access = accept && !line_hit;
    assign evict_start = miss_access && line_valid[cur_index] && line_modified[cur_index];
    assign refill_done = (state == read_wait) && mem_resp.valid;
    assign refill_ok   = refill_done && !mem_resp.error;

    // a request in the same idle cycle goes first, the walk waits
    assign walk_start  = (state == idle) && !dreq.valid && (do_writeback || wb_pending);
    assign walk_active = (state == walk_check) && (modified_count != '0);
    assign walk_dirty  = walk_active && line_valid[walk_index] && line_modified[walk_index];

    assign wb_load  = evict_start || walk_dirty;
    assign wb_index = walk_active ? walk_index : cur_index;

    // refill merges into the word from memory
    assign base_word    = (state == read_wait) ? mem_resp.rdata : line_data[cur_index];
    assign new_word     = update_word(base_word, cur_req);
    assign word_changed = (new_word != base_word);
    // loads and PTE accesses return the word as it was
    assign resp_word    = cur_req.wen ? new_word : base_word;

    assign count_inc = (hit_access && word_changed && !line_modified[cur_index])
                     || (refill_ok && word_changed);
    assign count_dec = ((state == evict_req) || (state == walk_req)) && mem_req_ready;

    assign req_ready          = (state == idle);
    assign is_writebacked_all = (modified_count == '0) && !wb_pending;

    assign dresp.valid = (state == resp) || hit_valid_q;
    assign dresp.error = resp_error_q;
    assign dresp.rdata = resp_rdata_q;

    assign mem_req.valid = (state == read_req) || (state == evict_req) || (state == walk_req);
    assign mem_req.wen   = (state != read_req);
    assign mem_req.addr  = (state == read_req) ? saved_req.addr : wb_addr;
    assign mem_req.wdata = wb_data;

    // control state
    always_ff @(posedge clk) begin
        if (reset) begin
            state          <= idle;
            line_valid     <= '0;
            line_modified  <= '0;
            modified_count <= '0;
            wb_pending     <= 1'b0;
            walk_index     <= '0;
            hit_valid_q    <= 1'b0;
        end else begin
            hit_valid_q <= hit_access;

            if (count_inc) begin
                modified_count <= modified_count + 1'b1;
            end else if (count_dec) begin
                modified_count <= modified_count - 1'b1;
            end

            if (walk_start) begin
                wb_pending <= 1'b0;
            end else if (do_writeback && (state != walk_check) && (state != walk_req)) begin
                wb_pending <= 1'b1;
            end

            case (state)
                idle: begin
                    if (hit_access) begin
                        line_modified[cur_index] <= line_modified[cur_index] | word_changed;
                    end else if (miss_access) begin
                        // line is reallocated to the new address
                        line_valid[cur_index]    <= 1'b0;
                        line_modified[cur_index] <= 1'b0;
                        state <= evict_start ? evict_req : read_req;
                    end else if (walk_start) begin
                        walk_index <= '0;
                        state      <= walk_check;
                    end
                end
                read_req: begin
                    if (mem_req_ready) begin
                        state <= read_wait;
                    end
                end
                read_wait: begin
                    if (refill_done) begin
                        // an error leaves the line invalid
                        line_valid[cur_index]    <= refill_ok;
                        line_modified[cur_index] <= refill_ok && word_changed;
                        state <= resp;
                    end
                end
                resp: begin
                    state <= idle;
                end
                evict_req: begin
                    if (mem_req_ready) begin
                        state <= read_req;
                    end
                end
                walk_check: begin
                    if (!walk_active) begin
                        state <= idle;
                    end else begin
                        line_valid[walk_index]    <= 1'b0;
                        line_modified[walk_index] <= 1'b0;
                        walk_index <= walk_index + 1'b1;
                        if (walk_dirty) begin
                            state <= walk_req;
                        end
                    end
                end
                walk_req: begin
                    if (mem_req_ready) begin
                        state <= walk_check;
                    end
                end
                default: begin
                    state <= idle;
                end
            endcase
        end
    end

    // line contents and request payload
    always_ff @(posedge clk) begin
        if (hit_access || refill_ok) begin
            line_data[cur_index] <= new_word;
        end
        if (miss_access) begin
            line_tag[cur_index] <= dreq.addr;
        end
        if (accept) begin
            saved_req <= dreq;
        end
        if (wb_load) begin
            wb_addr <= line_tag[wb_index];
            wb_data <= line_data[wb_index];
        end
        if (hit_access || refill_done) begin
            resp_error_q <= refill_done && mem_resp.error;
            resp_rdata_q <= resp_word;
        end
    end

endmodule

//--- verilog/main_memory.sv
/*
 * Word-addressed backing memory on the valid/ready bus.
 * Writes complete on acceptance. A read answers with one response
 * pulse a fixed number of cycles later; requests are refused while a
 * read is pending. Out-of-range writes are dropped and out-of-range
 * reads respond with error.
 */
module main_memory (
    input  logic                  clk,
    input  logic                  reset,
    input  memif_pkg::mem_req_t   mem_req,
    output logic                  mem_req_ready,
    output memif_pkg::mem_resp_t  mem_resp
);

    basic_pkg::word_t           mem_array [memif_pkg::MEM_WORDS];

    memif_pkg::mem_index_t      word_index;
    memif_pkg::latency_count_t  countdown;
    logic                       in_range;
    logic                       accept;
    logic                       read_pending;
    logic                       read_error_q;
    basic_pkg::word_t           read_data_q;

    assign word_index = mem_req.addr[memif_pkg::MEM_INDEX_BITS+1:2];
    // anything above the array is out of range
    assign in_range   = (mem_req.addr[31:memif_pkg::MEM_INDEX_BITS+2] == '0);
    assign accept     = mem_req.valid && mem_req_ready;

    assign mem_req_ready  = !read_pending;
    assign mem_resp.valid = read_pending && (countdown == '0);
    assign mem_resp.error = read_error_q;
    assign mem_resp.rdata = read_data_q;

    // read latency counter
    always_ff @(posedge clk) begin
        if (reset) begin
            read_pending <= 1'b0;
            countdown    <= '0;
        end else if (accept && !mem_req.wen) begin
            read_pending <= 1'b1;
            countdown    <= memif_pkg::latency_count_t'(memif_pkg::MEM_LATENCY - 1);
        end else if (read_pending) begin
            if (countdown == '0) begin
                read_pending <= 1'b0;
            end else begin
                countdown <= countdown - 1'b1;
            end
        end
    end

    // storage and read capture
    always_ff @(posedge clk) begin
        if (accept && mem_req.wen && in_range) begin
            mem_array[word_index] <= mem_req.wdata;
        end
        if (accept && !mem_req.wen) begin
            read_data_q  <= mem_array[word_index];
            read_error_q <= !in_range;
        end
    end

endmodule

//--- verilog/mem_subsys_top.sv
/*
 * Data-memory subsystem top level.
 * The write-back data cache in front of the backing memory, joined
 * by the valid/ready memory bus.
 */
module mem_subsys_top (
    input  logic                    clk,
    input  logic                    reset,
    input  memif_pkg::cache_req_t   dreq,
    output logic                    req_ready,
    output memif_pkg::cache_resp_t  dresp,
    input  logic                    do_writeback,
    output logic                    is_writebacked_all
);

    // cache to memory bus
    memif_pkg::mem_req_t    mem_req;
    logic                   mem_req_ready;
    memif_pkg::mem_resp_t   mem_resp;

    dcache dcache0 (
        .clk                (clk),
        .reset              (reset),
        .dreq               (dreq),
        .req_ready          (req_ready),
        .dresp              (dresp),
        .mem_req            (mem_req),
        .mem_req_ready      (mem_req_ready),
        .mem_resp           (mem_resp),
        .do_writeback       (do_writeback),
        .is_writebacked_all (is_writebacked_all)
    );

    main_memory main_memory0 (
        .clk                (clk),
        .reset              (reset),
        .mem_req            (mem_req),
        .mem_req_ready      (mem_req_ready),
        .mem_resp           (mem_resp)
    );

endmodule

//--- verilog/memif_pkg.sv
/*
 * Memory interface definitions.
 * Request and response structs for the core-side cache port and for
 * the valid/ready bus between the cache and the backing memory, along
 * with the size and latency of that memory.
 */
package memif_pkg;

    // backing memory of 4096 words, 16 KiB
    localparam int MEM_WORDS = 4096;
    localparam int MEM_INDEX_BITS = $clog2(MEM_WORDS);

    // cycles from read acceptance to response
    localparam int MEM_LATENCY = 3;
    localparam int MEM_LATENCY_BITS = $clog2(MEM_LATENCY + 1);

    typedef logic [MEM_INDEX_BITS-1:0] mem_index_t;
    typedef logic [MEM_LATENCY_BITS-1:0] latency_count_t;

    // core-side request
    typedef struct packed {
        logic               valid;
        logic               wen;
        basic_pkg::addr_t   addr;
        basic_pkg::word_t   wdata;
        basic_pkg::wmask_t  wmask;
        // page-table-entry access, A and D bits to set
        logic               pte_a;
        logic               pte_d;
    } cache_req_t;

    // core-side response, one-cycle pulse
    typedef struct packed {
        logic               valid;
        logic               error;
        basic_pkg::word_t   rdata;
    } cache_resp_t;

    // cache to memory, full words only
    typedef struct packed {
        logic               valid;
        logic               wen;
        basic_pkg::addr_t   addr;
        basic_pkg::word_t   wdata;
    } mem_req_t;

    // memory to cache, reads only
    typedef struct packed {
        logic               valid;
        logic               error;
        basic_pkg::word_t   rdata;
    } mem_resp_t;

endpackage
